//--- Bender.yml
package:
  name: riscv_core

sources:
  - files:
      - riscv_pkg.sv
      - fetch_stage.sv
      - reg_file.sv
      - decode_stage.sv
      - execute_stage.sv
      - writeback_stage.sv
      - riscv_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_riscv_core.sv

//--- build.f
+incdir+.
riscv_pkg.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
writeback_stage.sv
riscv_core.sv
tb_riscv_core.sv

//--- decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                 clk,
  input  logic                 rst_i,
  input  logic                 stall_i,
  input  logic                 flush_i,
  input  riscv_pkg::rv_instr_t instr_i,
  input  riscv_pkg::word_t     pc_i,
  input  riscv_pkg::reg_addr_t x_rd_i,
  input  logic                 x_reg_we_i,
  input  riscv_pkg::word_t     x_result_i,
  input  riscv_pkg::reg_addr_t wb_rd_i,
  input  logic                 wb_reg_we_i,
  input  riscv_pkg::word_t     wb_data_i,
  output logic                 jal_redirect_o,
  output riscv_pkg::word_t     jal_target_o,
  output riscv_pkg::word_t     ex_pc_o,
  output riscv_pkg::word_t     ex_rs1_o,
  output riscv_pkg::word_t     ex_rs2_o,
  output riscv_pkg::word_t     ex_imm_o,
  output logic [2:0]           ex_funct3_o,
  output riscv_pkg::reg_addr_t ex_rd_o,
  output logic [3:0]           ex_alu_op_o,
  output logic                 ex_a_sel_pc_o,
  output logic                 ex_b_sel_imm_o,
  output logic                 ex_reg_we_o,
  output logic                 ex_branch_o,
  output logic                 ex_jump_o,
  output logic                 ex_jalr_o,
  output logic                 ex_csr_we_o
);
  import riscv_pkg::*;

  word_t      rf_rdata_a;
  word_t      rf_rdata_b;
  logic       rf_we;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  word_t      imm;
  word_t      rs1_val;
  word_t      rs2_val;
  logic       csr_imm;
  logic       alt_imm;
  logic [3:0] alu_op;
  logic       a_sel_pc;
  logic       b_sel_imm;
  logic       reg_we;
  logic       branch;
  logic       jump;
  logic       jalr;
  logic       csr_we;

  // Freeze the register file along with the rest of the pipeline
  assign rf_we = wb_reg_we_i & ~stall_i;

  reg_file i_reg_file (
    .clk       (clk),
    .rst_i     (rst_i),
    .raddr_a_i (instr_i.r.rs1),
    .raddr_b_i (instr_i.r.rs2),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .we_i      (rf_we),
    .waddr_i   (wb_rd_i),
    .wdata_i   (wb_data_i)
  );

  //////////////////////////////
  // Immediates
  //////////////////////////////

  assign imm_i = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
  assign imm_b = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                  instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
  assign imm_u = {instr_i.u.imm, 12'b0};
  assign imm_j = {{11{instr_i.j.imm20}}, instr_i.j.imm20, instr_i.j.imm19_12,
                  instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};

  // JAL resolves here, one slot lost
  assign jal_redirect_o = (instr_i.r.opcode == OPC_JAL);
  assign jal_target_o   = pc_i + imm_j;

  //////////////////////////////
  // Control decode
  //////////////////////////////

  function automatic logic [3:0] alu_sel(input logic [2:0] funct3, input logic alt);
    case (funct3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // Only SRAI takes funct7 into account, ADDI bits there are immediate
  assign alt_imm = (instr_i.r.funct3 == 3'b101) && instr_i.r.funct7[5];

  always_comb begin
    alu_op    = ALU_ADD;
    a_sel_pc  = 1'b0;
    b_sel_imm = 1'b0;
    reg_we    = 1'b0;
    branch    = 1'b0;
    jump      = 1'b0;
    jalr      = 1'b0;
    csr_we    = 1'b0;
    imm       = imm_i;
    case (instr_i.r.opcode)
      OPC_LUI: begin
        alu_op    = ALU_COPY_B;
        b_sel_imm = 1'b1;
        imm       = imm_u;
        reg_we    = 1'b1;
      end
      OPC_AUIPC: begin
        a_sel_pc  = 1'b1;
        b_sel_imm = 1'b1;
        imm       = imm_u;
        reg_we    = 1'b1;
      end
      OPC_JAL: begin
        jump   = 1'b1;
        reg_we = 1'b1;
        imm    = imm_j;
      end
      OPC_JALR: begin
        jump      = 1'b1;
        jalr      = 1'b1;
        b_sel_imm = 1'b1;
        reg_we    = 1'b1;
      end
      OPC_BRANCH: begin
        branch = 1'b1;
        imm    = imm_b;
      end
      OPC_OP_IMM: begin
        alu_op    = alu_sel(instr_i.r.funct3, alt_imm);
        b_sel_imm = 1'b1;
        reg_we    = 1'b1;
      end
      OPC_OP: begin
        alu_op = alu_sel(instr_i.r.funct3, instr_i.r.funct7[5]);
        reg_we = 1'b1;
      end
      OPC_CSR: begin
        csr_we = 1'b1;
      end
      default: begin
        reg_we = 1'b0;
      end
    endcase
  end

  //////////////////////////////
  // Operand forwarding
  //////////////////////////////

  // Execute beats write-back, write-back beats the register file
  function automatic word_t forward(input reg_addr_t idx, input word_t rf_val);
    word_t val;
    if (idx == '0) begin
      val = '0;
    end else if (x_reg_we_i && x_rd_i == idx) begin
      val = x_result_i;
    end else if (wb_reg_we_i && wb_rd_i == idx) begin
      val = wb_data_i;
    end else begin
      val = rf_val;
    end
    return val;
  endfunction

  // CSRRWI carries its zero-extended uimm in place of rs1
  assign csr_imm = (instr_i.r.opcode == OPC_CSR) && instr_i.r.funct3[2];

  always_comb begin
    if (csr_imm) begin
      rs1_val = {{(XLEN-5){1'b0}}, instr_i.r.rs1};
    end else begin
      rs1_val = forward(instr_i.r.rs1, rf_rdata_a);
    end
    rs2_val = forward(instr_i.r.rs2, rf_rdata_b);
  end

  // Decode to execute register, an all-zero entry is a bubble
  always_ff @(posedge clk) begin
    if (rst_i || (flush_i && !stall_i)) begin
      ex_pc_o        <= '0;
      ex_rs1_o       <= '0;
      ex_rs2_o       <= '0;
      ex_imm_o       <= '0;
      ex_funct3_o    <= '0;
      ex_rd_o        <= '0;
      ex_alu_op_o    <= ALU_ADD;
      ex_a_sel_pc_o  <= 1'b0;
      ex_b_sel_imm_o <= 1'b0;
      ex_reg_we_o    <= 1'b0;
      ex_branch_o    <= 1'b0;
      ex_jump_o      <= 1'b0;
      ex_jalr_o      <= 1'b0;
      ex_csr_we_o    <= 1'b0;
    end else if (!stall_i) begin
      ex_pc_o        <= pc_i;
      ex_rs1_o       <= rs1_val;
      ex_rs2_o       <= rs2_val;
      ex_imm_o       <= imm;
      ex_funct3_o    <= instr_i.r.funct3;
      ex_rd_o        <= instr_i.r.rd;
      ex_alu_op_o    <= alu_op;
      ex_a_sel_pc_o  <= a_sel_pc;
      ex_b_sel_imm_o <= b_sel_imm;
      ex_reg_we_o    <= reg_we;
      ex_branch_o    <= branch;
      ex_jump_o      <= jump;
      ex_jalr_o      <= jalr;
      ex_csr_we_o    <= csr_we;
    end
  end

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  riscv_pkg::word_t     ex_pc_i,
  input  riscv_pkg::word_t     ex_rs1_i,
  input  riscv_pkg::word_t     ex_rs2_i,
  input  riscv_pkg::word_t     ex_imm_i,
  input  logic [2:0]           ex_funct3_i,
  input  riscv_pkg::reg_addr_t ex_rd_i,
  input  logic [3:0]           ex_alu_op_i,
  input  logic                 ex_a_sel_pc_i,
  input  logic                 ex_b_sel_imm_i,
  input  logic                 ex_reg_we_i,
  input  logic                 ex_branch_i,
  input  logic                 ex_jump_i,
  input  logic                 ex_jalr_i,
  input  logic                 ex_csr_we_i,
  output riscv_pkg::word_t     x_result_o,
  output riscv_pkg::reg_addr_t x_rd_o,
  output logic                 x_reg_we_o,
  output logic                 x_csr_we_o,
  output logic                 redirect_o,
  output riscv_pkg::word_t     target_o
);
  import riscv_pkg::*;

  word_t alu_a;
  word_t alu_b;
  word_t alu_res;
  word_t pc_plus_imm;
  logic  br_eq;
  logic  br_lt;
  logic  br_taken;

  //////////////////////////////
  // ALU
  //////////////////////////////

  assign alu_a = ex_a_sel_pc_i ? ex_pc_i : ex_rs1_i;
  assign alu_b = ex_b_sel_imm_i ? ex_imm_i : ex_rs2_i;

  always_comb begin
    case (ex_alu_op_i)
      ALU_ADD:    alu_res = alu_a + alu_b;
      ALU_SUB:    alu_res = alu_a - alu_b;
      ALU_SLL:    alu_res = alu_a << alu_b[4:0];
      ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      ALU_SLTU:   alu_res = {{(XLEN-1){1'b0}}, alu_a < alu_b};
      ALU_XOR:    alu_res = alu_a ^ alu_b;
      ALU_SRL:    alu_res = alu_a >> alu_b[4:0];
      ALU_SRA:    alu_res = word_t'($signed(alu_a) >>> alu_b[4:0]);
      ALU_OR:     alu_res = alu_a | alu_b;
      ALU_AND:    alu_res = alu_a & alu_b;
      ALU_COPY_B: alu_res = alu_b;
      default:    alu_res = alu_a + alu_b;
    endcase
  end

  //////////////////////////////
  // Branch and jump resolve
  //////////////////////////////

  // funct3[1] picks unsigned compare, funct3[0] inverts the outcome
  assign br_eq    = (ex_rs1_i == ex_rs2_i);
  assign br_lt    = ex_funct3_i[1] ? (ex_rs1_i < ex_rs2_i)
                                   : ($signed(ex_rs1_i) < $signed(ex_rs2_i));
  assign br_taken = ex_funct3_i[2] ? (br_lt ^ ex_funct3_i[0]) : (br_eq ^ ex_funct3_i[0]);

  assign pc_plus_imm = ex_pc_i + ex_imm_i;

  // JAL already redirected from decode, only JALR and branches act here
  assign redirect_o = ex_jalr_i | (ex_branch_i & br_taken);
  assign target_o   = ex_jalr_i ? {alu_res[XLEN-1:1], 1'b0} : pc_plus_imm;

  // Link value for jumps, source value for CSR writes
  always_comb begin
    if (ex_jump_i) begin
      x_result_o = ex_pc_i + PC_STEP;
    end else if (ex_csr_we_i) begin
      x_result_o = ex_rs1_i;
    end else begin
      x_result_o = alu_res;
    end
  end

  assign x_rd_o     = ex_rd_i;
  assign x_reg_we_o = ex_reg_we_i;
  assign x_csr_we_o = ex_csr_we_i;

endmodule

`default_nettype wire

//--- fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
  parameter riscv_pkg::word_t PC_RESET = '0
) (
  input  logic                 clk,
  input  logic                 rst_i,
  input  logic                 stall_i,
  input  logic                 x_redirect_i,
  input  riscv_pkg::word_t     x_target_i,
  input  logic                 jal_redirect_i,
  input  riscv_pkg::word_t     jal_target_i,
  output logic                 icache_re_o,
  output riscv_pkg::word_t     icache_addr_o,
  input  riscv_pkg::word_t     icache_dout_i,
  output riscv_pkg::rv_instr_t id_instr_o,
  output riscv_pkg::word_t     id_pc_o
);
  import riscv_pkg::*;

  word_t pc_q;
  word_t pc_next;
  word_t last_addr_q;
  logic  kill_q;

  // Replaying the last address keeps the returned word valid during a stall
  assign icache_re_o   = ~stall_i;
  assign icache_addr_o = stall_i ? last_addr_q : pc_q;

  // Execute redirect first, then JAL from decode
  always_comb begin
    if (x_redirect_i) begin
      pc_next = x_target_i;
    end else if (jal_redirect_i) begin
      pc_next = jal_target_i;
    end else begin
      pc_next = pc_q + PC_STEP;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q        <= PC_RESET;
      last_addr_q <= '0;
      kill_q      <= 1'b1;
    end else if (!stall_i) begin
      pc_q        <= pc_next;
      last_addr_q <= pc_q;
      kill_q      <= x_redirect_i | jal_redirect_i;
    end
  end

  // Word arriving now belongs to the address sent last cycle
  assign id_instr_o = kill_q ? INSTR_NOP : icache_dout_i;
  assign id_pc_o    = last_addr_q;

  pc_aligned_a : assert property (@(posedge clk) disable iff (rst_i) pc_q[1:0] == 2'b00)
    else $error("fetch PC not word aligned: %h", pc_q);

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic                 clk,
  input  logic                 rst_i,
  input  riscv_pkg::reg_addr_t raddr_a_i,
  input  riscv_pkg::reg_addr_t raddr_b_i,
  output riscv_pkg::word_t     rdata_a_o,
  output riscv_pkg::word_t     rdata_b_o,
  input  logic                 we_i,
  input  riscv_pkg::reg_addr_t waddr_i,
  input  riscv_pkg::word_t     wdata_i
);
  import riscv_pkg::*;

  // x1 to x31, x0 has no storage
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

  // Write-back must already have dropped writes to x0
  no_x0_write_a : assert property (@(posedge clk) disable iff (rst_i) we_i |-> waddr_i != '0)
    else $error("register write enabled to x0");

endmodule

`default_nettype wire

//--- riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core #(
  parameter riscv_pkg::word_t PC_RESET = '0
) (
  input  logic             clk,
  input  logic             rst_i,
  input  logic             stall_i,
  output logic             icache_re_o,
  output riscv_pkg::word_t icache_addr_o,
  input  riscv_pkg::word_t icache_dout_i,
  output riscv_pkg::word_t csr_o
);
  import riscv_pkg::*;

  // Fetch to decode
  rv_instr_t  id_instr;
  word_t      id_pc;
  logic       jal_redirect;
  word_t      jal_target;

  // Decode to execute
  word_t      ex_pc;
  word_t      ex_rs1;
  word_t      ex_rs2;
  word_t      ex_imm;
  logic [2:0] ex_funct3;
  reg_addr_t  ex_rd;
  logic [3:0] ex_alu_op;
  logic       ex_a_sel_pc;
  logic       ex_b_sel_imm;
  logic       ex_reg_we;
  logic       ex_branch;
  logic       ex_jump;
  logic       ex_jalr;
  logic       ex_csr_we;

  // Execute results and redirect
  word_t      x_result;
  reg_addr_t  x_rd;
  logic       x_reg_we;
  logic       x_csr_we;
  logic       x_redirect;
  word_t      x_target;

  // Write-back to register file and forwarding
  reg_addr_t  wb_rd;
  logic       wb_reg_we;
  word_t      wb_data;

  fetch_stage #(
    .PC_RESET (PC_RESET)
  ) i_fetch (
    .clk            (clk),
    .rst_i          (rst_i),
    .stall_i        (stall_i),
    .x_redirect_i   (x_redirect),
    .x_target_i     (x_target),
    .jal_redirect_i (jal_redirect),
    .jal_target_i   (jal_target),
    .icache_re_o    (icache_re_o),
    .icache_addr_o  (icache_addr_o),
    .icache_dout_i  (icache_dout_i),
    .id_instr_o     (id_instr),
    .id_pc_o        (id_pc)
  );

  decode_stage i_decode (
    .clk            (clk),
    .rst_i          (rst_i),
    .stall_i        (stall_i),
    .flush_i        (x_redirect),
    .instr_i        (id_instr),
    .pc_i           (id_pc),
    .x_rd_i         (x_rd),
    .x_reg_we_i     (x_reg_we),
    .x_result_i     (x_result),
    .wb_rd_i        (wb_rd),
    .wb_reg_we_i    (wb_reg_we),
    .wb_data_i      (wb_data),
    .jal_redirect_o (jal_redirect),
    .jal_target_o   (jal_target),
    .ex_pc_o        (ex_pc),
    .ex_rs1_o       (ex_rs1),
    .ex_rs2_o       (ex_rs2),
    .ex_imm_o       (ex_imm),
    .ex_funct3_o    (ex_funct3),
    .ex_rd_o        (ex_rd),
    .ex_alu_op_o    (ex_alu_op),
    .ex_a_sel_pc_o  (ex_a_sel_pc),
    .ex_b_sel_imm_o (ex_b_sel_imm),
    .ex_reg_we_o    (ex_reg_we),
    .ex_branch_o    (ex_branch),
    .ex_jump_o      (ex_jump),
    .ex_jalr_o      (ex_jalr),
    .ex_csr_we_o    (ex_csr_we)
  );

  execute_stage i_execute (
    .ex_pc_i        (ex_pc),
    .ex_rs1_i       (ex_rs1),
    .ex_rs2_i       (ex_rs2),
    .ex_imm_i       (ex_imm),
    .ex_funct3_i    (ex_funct3),
    .ex_rd_i        (ex_rd),
    .ex_alu_op_i    (ex_alu_op),
    .ex_a_sel_pc_i  (ex_a_sel_pc),
    .ex_b_sel_imm_i (ex_b_sel_imm),
    .ex_reg_we_i    (ex_reg_we),
    .ex_branch_i    (ex_branch),
    .ex_jump_i      (ex_jump),
    .ex_jalr_i      (ex_jalr),
    .ex_csr_we_i    (ex_csr_we),
    .x_result_o     (x_result),
    .x_rd_o         (x_rd),
    .x_reg_we_o     (x_reg_we),
    .x_csr_we_o     (x_csr_we),
    .redirect_o     (x_redirect),
    .target_o       (x_target)
  );

  writeback_stage i_writeback (
    .clk         (clk),
    .rst_i       (rst_i),
    .stall_i     (stall_i),
    .x_result_i  (x_result),
    .x_rd_i      (x_rd),
    .x_reg_we_i  (x_reg_we),
    .x_csr_we_i  (x_csr_we),
    .wb_rd_o     (wb_rd),
    .wb_reg_we_o (wb_reg_we),
    .wb_data_o   (wb_data),
    .csr_o       (csr_o)
  );

endmodule

`default_nettype wire

//--- riscv_pkg.sv
`default_nettype none

package riscv_pkg;

  //////////////////////////////
  // Widths and basic types
  //////////////////////////////

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  // One instruction word seen through each base format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      reg_addr_t  rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      reg_addr_t   rs1;
      logic [2:0]  funct3;
      reg_addr_t   rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm;
      reg_addr_t   rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      reg_addr_t  rd;
      logic [6:0] opcode;
    } j;
  } rv_instr_t;

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_CSR    = 7'b1110011;

  // ALU function select
  localparam logic [3:0] ALU_ADD    = 4'd0;
  localparam logic [3:0] ALU_SUB    = 4'd1;
  localparam logic [3:0] ALU_SLL    = 4'd2;
  localparam logic [3:0] ALU_SLT    = 4'd3;
  localparam logic [3:0] ALU_SLTU   = 4'd4;
  localparam logic [3:0] ALU_XOR    = 4'd5;
  localparam logic [3:0] ALU_SRL    = 4'd6;
  localparam logic [3:0] ALU_SRA    = 4'd7;
  localparam logic [3:0] ALU_OR     = 4'd8;
  localparam logic [3:0] ALU_AND    = 4'd9;
  localparam logic [3:0] ALU_COPY_B = 4'd10;

  // addi x0, x0, 0
  localparam word_t INSTR_NOP = 32'h0000_0013;
  localparam word_t PC_STEP   = 32'd4;

endpackage

`default_nettype wire

//--- tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

////////////////////////////////
// Instruction encoders
////////////////////////////////

int wr_idx;

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] op);
  return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {imm, rd, op};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
endfunction

function automatic logic [31:0] csrrw(input logic [4:0] rs1);
  return enc_i(12'h0, rs1, 3'b001, 5'd0, 7'h73);
endfunction

function automatic logic [31:0] csrrwi(input logic [4:0] uimm);
  return enc_i(12'h0, uimm, 3'b101, 5'd0, 7'h73);
endfunction

task automatic emit(input logic [31:0] w);
  mem[wr_idx] = w;
  wr_idx++;
endtask

function automatic logic [31:0] xorshift(input logic [31:0] s);
  logic [31:0] v;
  v = s ^ (s << 13);
  v = v ^ (v >> 17);
  v = v ^ (v << 5);
  return v;
endfunction

////////////////////////////////
// Test programs
////////////////////////////////

task automatic load_program(input int prog);
  int k;
  int f;
  int p;
  logic [4:0] ra;
  logic [4:0] rb;
  // addi x0,x0,k so every word differs by address
  for (k = 0; k < MEM_WORDS; k++) begin
    mem[k] = {4'h0, k[7:0], 20'h00013};
  end
  wr_idx = 0;
  case (prog)
    0: begin
      emit(enc_u(20'hfedcb, 5'd1, 7'h37));
      emit(csrrw(5'd1));
      emit(enc_i(12'h765, 5'd1, 3'd0, 5'd2, 7'h13));
      emit(csrrw(5'd2));
      emit(enc_i(12'h4b3, 5'd0, 3'd0, 5'd4, 7'h13));
      emit(enc_u(20'h00010, 5'd3, 7'h17));
      emit(csrrw(5'd3));
      for (f = 0; f < 8; f++) begin
        emit(enc_r(7'h00, 5'd4, 5'd2, f[2:0], 5'd5, 7'h33));
        emit(csrrw(5'd5));
        emit(enc_i((f == 1 || f == 5) ? 12'd7 : 12'h9a5, 5'd2, f[2:0], 5'd6, 7'h13));
        emit(csrrw(5'd6));
        if (f == 0 || f == 5) begin
          emit(enc_r(7'h20, 5'd4, 5'd2, f[2:0], 5'd5, 7'h33));
          emit(csrrw(5'd5));
        end
      end
      // srai by 13
      emit(enc_i(12'h40d, 5'd2, 3'd5, 5'd6, 7'h13));
      emit(csrrw(5'd6));
    end
    1: begin
      emit(enc_i(12'd5, 5'd0, 3'd0, 5'd1, 7'h13));
      emit(enc_i(12'd3, 5'd1, 3'd0, 5'd2, 7'h13));
      emit(enc_i(12'd11, 5'd0, 3'd0, 5'd3, 7'h13));
      emit(enc_r(7'h00, 5'd3, 5'd1, 3'd0, 5'd4, 7'h33));
      emit(enc_r(7'h00, 5'd2, 5'd4, 3'd0, 5'd5, 7'h33));
      emit(enc_r(7'h20, 5'd4, 5'd5, 3'd0, 5'd6, 7'h33));
      emit(csrrw(5'd6));
      emit(enc_r(7'h00, 5'd1, 5'd6, 3'd4, 5'd7, 7'h33));
      emit(csrrw(5'd7));
      emit(enc_r(7'h00, 5'd5, 5'd7, 3'd0, 5'd8, 7'h33));
      emit(enc_i(12'd0, 5'd0, 3'd0, 5'd0, 7'h13));
      emit(csrrw(5'd8));
      emit(csrrw(5'd5));
      emit(enc_r(7'h00, 5'd1, 5'd8, 3'd1, 5'd9, 7'h33));
      emit(csrrw(5'd9));
    end
    2: begin
      // x1 = -3, x2 = x3 = 5
      emit(enc_i(12'hffd, 5'd0, 3'd0, 5'd1, 7'h13));
      emit(enc_i(12'd5, 5'd0, 3'd0, 5'd2, 7'h13));
      emit(enc_i(12'd5, 5'd0, 3'd0, 5'd3, 7'h13));
      k = 0;
      for (f = 0; f < 8; f++) begin
        if (f != 2 && f != 3) begin
          for (p = 0; p < 3; p++) begin
            ra = (p == 0) ? 5'd1 : 5'd2;
            rb = (p == 0) ? 5'd2 : ((p == 1) ? 5'd1 : 5'd3);
            emit(enc_b(13'd12, rb, ra, f[2:0]));
            emit(csrrwi(5'(k)));
            emit(enc_j(21'd8, 5'd0));
            emit(csrrwi(5'(k + 16)));
            k++;
          end
        end
      end
    end
    default: begin
      emit(enc_j(21'd12, 5'd1));
      emit(csrrwi(5'd3));
      emit(csrrwi(5'd4));
      emit(csrrw(5'd1));
      emit(enc_i(12'd44, 5'd0, 3'd0, 5'd5, 7'h13));
      // Odd offset, bit 0 of the target is dropped
      emit(enc_i(12'd1, 5'd5, 3'd0, 5'd6, 7'h67));
      for (k = 7; k < 12; k++) begin
        emit(csrrwi(5'(k)));
      end
      emit(csrrw(5'd6));
      emit(csrrwi(5'd21));
      emit(enc_j(21'd8, 5'd7));
      emit(csrrwi(5'd9));
      emit(csrrw(5'd7));
      emit(enc_i(12'd80, 5'd0, 3'd0, 5'd8, 7'h13));
      emit(enc_i(12'd0, 5'd8, 3'd0, 5'd9, 7'h67));
      emit(csrrwi(5'd12));
      emit(csrrwi(5'd13));
      emit(csrrw(5'd9));
      emit(csrrwi(5'd30));
    end
  endcase
  // Self loop marks the end
  emit(enc_j(21'd0, 5'd0));
endtask

////////////////////////////////
// Instruction-level reference
////////////////////////////////

function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'd0:    return alt ? a - b : a + b;
    3'd1:    return a << b[4:0];
    3'd2:    return {31'b0, $signed(a) < $signed(b)};
    3'd3:    return {31'b0, a < b};
    3'd4:    return a ^ b;
    3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6:    return a | b;
    default: return a & b;
  endcase
endfunction

// Runs the loaded program and queues every change of the csr
function automatic void run_reference();
  logic [31:0] x [32];
  logic [31:0] pc;
  logic [31:0] ins;
  logic [31:0] res;
  logic [31:0] next_pc;
  logic [31:0] csr_val;
  logic [31:0] imm_i;
  logic [31:0] src;
  logic [2:0]  f3;
  logic        wr;
  logic        taken;
  int          steps;
  exp_q.delete();
  for (int r = 0; r < 32; r++) begin
    x[r] = '0;
  end
  pc = '0;
  csr_val = '0;
  for (steps = 0; steps < 4000; steps++) begin
    ins = mem[pc[9:2]];
    if (ins == 32'h0000_006f) begin
      break;
    end
    f3 = ins[14:12];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    next_pc = pc + 4;
    res = '0;
    wr = 1'b0;
    case (ins[6:0])
      7'h37: begin
        res = {ins[31:12], 12'b0};
        wr = 1'b1;
      end
      7'h17: begin
        res = pc + {ins[31:12], 12'b0};
        wr = 1'b1;
      end
      7'h6f: begin
        res = pc + 4;
        next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        wr = 1'b1;
      end
      7'h67: begin
        res = pc + 4;
        next_pc = (x[ins[19:15]] + imm_i) & 32'hffff_fffe;
        wr = 1'b1;
      end
      7'h63: begin
        case (f3)
          3'd0:    taken = x[ins[19:15]] == x[ins[24:20]];
          3'd1:    taken = x[ins[19:15]] != x[ins[24:20]];
          3'd4:    taken = $signed(x[ins[19:15]]) < $signed(x[ins[24:20]]);
          3'd5:    taken = $signed(x[ins[19:15]]) >= $signed(x[ins[24:20]]);
          3'd6:    taken = x[ins[19:15]] < x[ins[24:20]];
          default: taken = x[ins[19:15]] >= x[ins[24:20]];
        endcase
        if (taken) begin
          next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      7'h13: begin
        res = ref_alu(f3, f3 == 3'd5 && ins[30], x[ins[19:15]], imm_i);
        wr = 1'b1;
      end
      7'h33: begin
        res = ref_alu(f3, ins[30], x[ins[19:15]], x[ins[24:20]]);
        wr = 1'b1;
      end
      7'h73: begin
        src = f3[2] ? {27'b0, ins[19:15]} : x[ins[19:15]];
        if (src != csr_val) begin
          exp_q.push_back(src);
        end
        csr_val = src;
      end
      default: begin
        wr = 1'b0;
      end
    endcase
    if (wr && ins[11:7] != 5'd0) begin
      x[ins[11:7]] = res;
    end
    pc = next_pc;
  end
endfunction

`endif

//--- tb_riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_core;

  localparam int MEM_WORDS = 256;
  localparam int TIMEOUT   = 3000;

  logic        clk;
  logic        rst_i;
  logic        stall_i;
  logic        icache_re;
  logic [31:0] icache_addr;
  logic [31:0] icache_dout;
  logic [31:0] csr;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] exp_q [$];
  logic [31:0] rng_state;
  logic [31:0] last_csr;
  logic [31:0] prev_addr;
  logic        stall_en;
  logic        checking;

  `include "tb_ref_model.svh"

  riscv_core #(
    .PC_RESET (32'h0)
  ) i_dut (
    .clk           (clk),
    .rst_i         (rst_i),
    .stall_i       (stall_i),
    .icache_re_o   (icache_re),
    .icache_addr_o (icache_addr),
    .icache_dout_i (icache_dout),
    .csr_o         (csr)
  );

  always #20 clk = ~clk;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1);
  endtask

  // One-cycle cache that holds its word while reads are off
  always @(posedge clk) begin
    if (!rst_i) begin
      assert (icache_re === !stall_i)
        else report_failure($sformatf("MISMATCH at %0t: icache_re_o = %b, expected %b",
                                      $time, icache_re, !stall_i));
      // A stalled cycle replays the previous address
      if (stall_i) begin
        assert (icache_addr === prev_addr)
          else report_failure($sformatf("MISMATCH at %0t: icache_addr_o = %h, expected %h",
                                        $time, icache_addr, prev_addr));
      end
    end
    prev_addr <= icache_addr;
    if (icache_re) begin
      icache_dout <= mem[icache_addr[9:2]];
    end
  end

  // Random stall on about a third of the cycles
  always @(negedge clk) begin
    rng_state = xorshift(rng_state);
    stall_i <= stall_en && (rng_state % 3 == 0);
  end

  // Compare each visible csr change with the next reference value
  always @(negedge clk) begin
    if (checking && csr !== last_csr) begin
      assert (exp_q.size() > 0)
        else report_failure($sformatf("csr_o changed to %h more often than expected", csr));
      assert (csr === exp_q[0])
        else report_failure($sformatf("MISMATCH at %0t: csr_o = %h, expected %h",
                                      $time, csr, exp_q[0]));
      last_csr = csr;
      void'(exp_q.pop_front());
    end
  end

  task automatic run_test(input int prog, input logic with_stall);
    int cycles;
    checking = 1'b0;
    @(negedge clk);
    rst_i = 1'b1;
    stall_en = with_stall;
    load_program(prog);
    run_reference();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    last_csr = '0;
    checking = 1'b1;
    cycles = 0;
    while (exp_q.size() > 0) begin
      @(posedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        report_failure($sformatf("program %0d timed out with %0d csr values missing",
                                 prog, exp_q.size()));
      end
    end
    // Late writes after the last value would show up here
    repeat (40) @(posedge clk);
    checking = 1'b0;
    $display("program %0d with stall %0b done", prog, with_stall);
  endtask

  initial begin
    clk = 1'b0;
    rst_i = 1'b1;
    stall_i = 1'b0;
    icache_dout = '0;
    stall_en = 1'b0;
    checking = 1'b0;
    last_csr = '0;
    prev_addr = '0;
    rng_state = 32'd26809;
    for (int s = 0; s < 2; s++) begin
      for (int p = 0; p < 4; p++) begin
        run_test(p, s[0]);
      end
    end
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
  input  logic                 clk,
  input  logic                 rst_i,
  input  logic                 stall_i,
  input  riscv_pkg::word_t     x_result_i,
  input  riscv_pkg::reg_addr_t x_rd_i,
  input  logic                 x_reg_we_i,
  input  logic                 x_csr_we_i,
  output riscv_pkg::reg_addr_t wb_rd_o,
  output logic                 wb_reg_we_o,
  output riscv_pkg::word_t     wb_data_o,
  output riscv_pkg::word_t     csr_o
);
  import riscv_pkg::*;

  word_t     result_q;
  reg_addr_t rd_q;
  logic      reg_we_q;
  logic      csr_we_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      result_q <= '0;
      rd_q     <= '0;
      reg_we_q <= 1'b0;
      csr_we_q <= 1'b0;
      csr_o    <= '0;
    end else if (!stall_i) begin
      result_q <= x_result_i;
      rd_q     <= x_rd_i;
      reg_we_q <= x_reg_we_i;
      csr_we_q <= x_csr_we_i;
      // csr updates at the end of the write-back cycle
      if (csr_we_q) begin
        csr_o <= result_q;
      end
    end
  end

  // Writes to x0 never leave this stage
  assign wb_rd_o     = rd_q;
  assign wb_reg_we_o = reg_we_q && (rd_q != '0);
  assign wb_data_o   = result_q;

  // CSR instructions carry no rd write from decode onward
  csr_no_rd_a : assert property (@(posedge clk) disable iff (rst_i) csr_we_q |-> !reg_we_q)
    else $error("CSR write with register write enabled");

endmodule

`default_nettype wire
